//--- arith/lane_adder.sv
`timescale 1ns/10ps
`include "simd_alu_settings.svh"

module lane_adder (
	input  simd_alu_pkg::word_t       ra,
	input  simd_alu_pkg::word_t       rb,
	input  simd_alu_pkg::lane_width_e ww,
	input  logic                      subtract,
	output simd_alu_pkg::word_t       sum
);

	// Byte slices, slice 0 is the least significant byte
	localparam int SEGS = `SIMD_WORD_BITS / 8;

	// rb after inversion for subtract
	simd_alu_pkg::word_t b_op;
	// Set where a lane begins at slice s
	logic [SEGS-1:1] lane_start;
	wire  [SEGS-1:0] cin;
	wire  [SEGS-2:0] cout;
	wire  [`SIMD_WORD_BITS-1:0] seg_sum;

	// Two's complement: invert here, +1 enters at each lane start
	assign b_op = subtract ? ~rb : rb;

	// Lane boundaries per width
	always_comb begin
		case (ww)
			simd_alu_pkg::WIDTH_8:  lane_start = 7'b111_1111;
			simd_alu_pkg::WIDTH_16: lane_start = 7'b010_1010;
			simd_alu_pkg::WIDTH_32: lane_start = 7'b000_1000;
			default:                lane_start = 7'b000_0000;
		endcase
	end

	for (genvar s = 0; s < SEGS; s++) begin : g_seg
		if (s == 0) begin : g_first
			assign cin[s] = subtract;
		end else begin : g_chain
			// Carry killed at a lane start
			// Subtract increment takes its place
			assign cin[s] = lane_start[s] ? subtract : cout[s-1];
		end

		if (s < SEGS - 1) begin : g_carry
			assign {cout[s], seg_sum[8*s+7 -: 8]} =
				{1'b0, ra[8*s+7 -: 8]} + {1'b0, b_op[8*s+7 -: 8]} + {8'd0, cin[s]};
		end else begin : g_top
			// Carry out of the top byte is always dropped
			assign seg_sum[8*s+7 -: 8] = ra[8*s+7 -: 8] + b_op[8*s+7 -: 8] + {7'd0, cin[s]};
		end
	end

	assign sum = seg_sum;

endmodule

//--- arith/lane_multiplier.sv
`timescale 1ns/10ps
`include "simd_alu_settings.svh"

module lane_multiplier (
	input  simd_alu_pkg::word_t       ra,
	input  simd_alu_pkg::word_t       rb,
	input  simd_alu_pkg::lane_width_e ww,
	input  logic                      odd_sel,
	input  logic                      square_sel,
	output simd_alu_pkg::word_t       product
);

	localparam int WB = `SIMD_WORD_BITS;

	// Second factor, ra itself for squares
	simd_alu_pkg::word_t b_src;
	// Product words for 8, 16 and 32-bit elements
	wire [WB-1:0] prod_w [3];

	assign b_src = square_sel ? ra : rb;

	for (genvar w = 0; w < 3; w++) begin : g_width
		// Element width and number of element pairs in the word
		localparam int EW = 8 << w;
		localparam int PAIRS = WB / (2 * EW);

		for (genvar k = 0; k < PAIRS; k++) begin : g_pair
			// Pair k covers elements 2k and 2k+1
			// Its double-width product lands on the same bits
			localparam int HI = WB - 1 - k * 2 * EW;

			logic [EW-1:0] op_a;
			logic [EW-1:0] op_b;

			// Even element is the upper one of the pair
			assign op_a = odd_sel ? ra[HI-EW -: EW] : ra[HI -: EW];
			assign op_b = odd_sel ? b_src[HI-EW -: EW] : b_src[HI -: EW];

			// Unsigned, full width, no truncation
			assign prod_w[w][HI -: 2*EW] = (2*EW)'(op_a) * (2*EW)'(op_b);
		end
	end

	// 64x64 has no double-width lane to land in
	always_comb begin
		case (ww)
			simd_alu_pkg::WIDTH_8:  product = prod_w[0];
			simd_alu_pkg::WIDTH_16: product = prod_w[1];
			simd_alu_pkg::WIDTH_32: product = prod_w[2];
			default:                product = '0;
		endcase
	end

endmodule

//--- arith/lane_sqrt.sv
`timescale 1ns/10ps
`include "simd_alu_settings.svh"

module lane_sqrt (
	input  simd_alu_pkg::word_t       ra,
	input  simd_alu_pkg::lane_width_e ww,
	output simd_alu_pkg::word_t       root
);

	localparam int WB = `SIMD_WORD_BITS;

	// Root words for 8, 16, 32 and 64-bit lanes
	wire [WB-1:0] root_w [4];

	for (genvar w = 0; w < 4; w++) begin : g_width
		localparam int EW = 8 << w;
		localparam int NL = WB / EW;
		// Root bits per lane
		localparam int RB = EW / 2;

		for (genvar l = 0; l < NL; l++) begin : g_lane
			localparam int HI = WB - 1 - l * EW;

			logic [EW-1:0] rad;
			logic [RB-1:0] q;
			// Signed partial remainder, two bits wider than the root
			logic [RB+1:0] r;

			assign rad = ra[HI -: EW];

			// Non-restoring, one root bit per radicand bit pair
			// Remainder kept mod 2^(RB+2), final value always fits
			always_comb begin
				q = '0;
				r = '0;
				for (int i = RB - 1; i >= 0; i--) begin
					if (!r[RB+1]) begin
						r = {r[RB-1:0], rad[2*i+1 -: 2]} - {q, 2'b01};
					end else begin
						r = {r[RB-1:0], rad[2*i+1 -: 2]} + {q, 2'b11};
					end
					// Non-negative remainder gives a one
					q = {q[RB-2:0], ~r[RB+1]};
				end
			end

			// Zero-extend into the lane
			assign root_w[w][HI -: EW] = {{RB{1'b0}}, q};
		end
	end

	always_comb begin
		case (ww)
			simd_alu_pkg::WIDTH_8:  root = root_w[0];
			simd_alu_pkg::WIDTH_16: root = root_w[1];
			simd_alu_pkg::WIDTH_32: root = root_w[2];
			default:                root = root_w[3];
		endcase
	end

endmodule

//--- common/simd_alu_pkg.sv
`include "simd_alu_settings.svh"

package simd_alu_pkg;

	// One register value, element 0 in the top lane
	typedef logic [`SIMD_WORD_BITS-1:0] word_t;

	// Major opcodes
	// Only R_ALU reaches the ALU functions, the rest decode to a zero result
	typedef enum logic [`SIMD_OPCODE_BITS-1:0] {
		LOAD      = 6'b100000,
		STORE     = 6'b100001,
		BRANCH_EZ = 6'b100010,
		BRANCH_NZ = 6'b100011,
		R_ALU     = 6'b101010,
		NOP       = 6'b111100
	} opcode_e;

	// R-type function codes
	// Gaps at 12, 14 and 15 are the dropped shift-arith, divide and modulo
	typedef enum logic [`SIMD_FUNC_BITS-1:0] {
		VNOP   = 6'b000000,
		VAND   = 6'b000001,
		VOR    = 6'b000010,
		VXOR   = 6'b000011,
		VNOT   = 6'b000100,
		VMOV   = 6'b000101,
		VADD   = 6'b000110,
		VSUB   = 6'b000111,
		VMULEU = 6'b001000,
		VMULOU = 6'b001001,
		VSLL   = 6'b001010,
		VSRL   = 6'b001011,
		VRTTH  = 6'b001101,
		VSQEU  = 6'b010000,
		VSQOU  = 6'b010001,
		VSQRT  = 6'b010010
	} func_e;

	// Lane width
	typedef enum logic [`SIMD_WW_BITS-1:0] {
		WIDTH_8  = 2'b00,
		WIDTH_16 = 2'b01,
		WIDTH_32 = 2'b10,
		WIDTH_64 = 2'b11
	} lane_width_e;

endpackage

//--- common/simd_alu_settings.svh
`ifndef SIMD_ALU_SETTINGS_SVH
`define SIMD_ALU_SETTINGS_SVH

// Operand and result width of the execute stage
// Element 0 always sits in the most significant lane
`define SIMD_WORD_BITS 64

// Major opcode field, INSTR[0:5] in the decode stage
`define SIMD_OPCODE_BITS 6

// Function code field of an R-type instruction
`define SIMD_FUNC_BITS 6

// Lane-width code
// 8, 16, 32 or 64-bit elements
`define SIMD_WW_BITS 2

`endif

//--- filelist.f
+incdir+common
+incdir+verif
common/simd_alu_pkg.sv
arith/lane_adder.sv
arith/lane_multiplier.sv
arith/lane_sqrt.sv
verilog/lane_shift_rotate.sv
verilog/alu_result_stage.sv
verilog/simd_alu_top.sv
verif/simd_alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SIMD ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f \
	--top-module simd_alu_tb -o simd_alu_sim

./obj_dir/simd_alu_sim | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

//--- verif/simd_alu_model.svh
`ifndef SIMD_ALU_MODEL_SVH
`define SIMD_ALU_MODEL_SVH

// Element width in bits for a lane-width code
function automatic int lane_bits(input simd_alu_pkg::lane_width_e w);
	return 8 << int'(w);
endfunction

// Element idx of a word, element 0 is the top lane
function automatic logic [63:0] get_elem(input logic [63:0] w, input int ew, input int idx);
	logic [63:0] v;
	v = w >> (64 - ew * (idx + 1));
	if (ew < 64) begin
		v = v & ((64'd1 << ew) - 64'd1);
	end
	return v;
endfunction

// Overwrite element idx, value truncated to the element width
function automatic logic [63:0] put_elem(input logic [63:0] w, input int ew, input int idx,
		input logic [63:0] v);
	logic [63:0] mask;
	int sh;
	sh = 64 - ew * (idx + 1);
	mask = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
	return (w & ~(mask << sh)) | ((v & mask) << sh);
endfunction

// Largest r with r*r <= x, one bit at a time
function automatic logic [63:0] floor_sqrt(input logic [63:0] x);
	logic [63:0] r;
	logic [63:0] t;
	r = '0;
	for (int b = 31; b >= 0; b--) begin
		t = r | (64'd1 << b);
		if (t * t <= x) begin
			r = t;
		end
	end
	return r;
endfunction

// Expected registered result of one operation
function automatic logic [63:0] expected_result(input simd_alu_pkg::opcode_e op,
		input simd_alu_pkg::func_e fn, input simd_alu_pkg::lane_width_e w,
		input logic [63:0] a, input logic [63:0] b);
	logic [63:0] res;
	logic [63:0] x;
	logic [63:0] y;
	logic [63:0] amt;
	int ew;
	int n;
	ew = lane_bits(w);
	n = 64 / ew;
	res = '0;
	// Only the register-ALU opcode does anything
	if (op != simd_alu_pkg::R_ALU) begin
		return '0;
	end
	case (fn)
		simd_alu_pkg::VAND: res = a & b;
		simd_alu_pkg::VOR:  res = a | b;
		simd_alu_pkg::VXOR: res = a ^ b;
		simd_alu_pkg::VNOT: res = ~a;
		simd_alu_pkg::VMOV: res = a;
		simd_alu_pkg::VADD, simd_alu_pkg::VSUB: begin
			// Wrap inside each lane
			for (int i = 0; i < n; i++) begin
				x = get_elem(a, ew, i);
				y = get_elem(b, ew, i);
				res = put_elem(res, ew, i, (fn == simd_alu_pkg::VSUB) ? x - y : x + y);
			end
		end
		simd_alu_pkg::VMULEU, simd_alu_pkg::VMULOU,
		simd_alu_pkg::VSQEU, simd_alu_pkg::VSQOU: begin
			// No double-width lane at 64 bits, result stays zero
			if (ew < 64) begin
				for (int k = 0; k < n / 2; k++) begin
					x = get_elem(a, ew, 2 * k + (fn == simd_alu_pkg::VMULOU ||
						fn == simd_alu_pkg::VSQOU ? 1 : 0));
					y = get_elem(b, ew, 2 * k + (fn == simd_alu_pkg::VMULOU ? 1 : 0));
					if (fn == simd_alu_pkg::VSQEU || fn == simd_alu_pkg::VSQOU) begin
						y = x;
					end
					res = put_elem(res, 2 * ew, k, x * y);
				end
			end
		end
		simd_alu_pkg::VSLL, simd_alu_pkg::VSRL, simd_alu_pkg::VRTTH: begin
			for (int i = 0; i < n; i++) begin
				x = get_elem(a, ew, i);
				// Low log2(width) bits of the rB lane
				amt = get_elem(b, ew, i) & 64'(ew - 1);
				if (fn == simd_alu_pkg::VSLL) begin
					res = put_elem(res, ew, i, x << amt);
				end else if (fn == simd_alu_pkg::VSRL) begin
					res = put_elem(res, ew, i, x >> amt);
				end else begin
					res = put_elem(res, ew, i, (x << (ew / 2)) | (x >> (ew / 2)));
				end
			end
		end
		simd_alu_pkg::VSQRT: begin
			for (int i = 0; i < n; i++) begin
				res = put_elem(res, ew, i, floor_sqrt(get_elem(a, ew, i)));
			end
		end
		default: res = '0;
	endcase
	return res;
endfunction

`endif

//--- verif/simd_alu_tb.sv
`timescale 1ns/10ps

module simd_alu_tb;

	logic clk;
	logic rst_n;
	logic ex_valid;
	logic [63:0] ra;
	logic [63:0] rb;
	simd_alu_pkg::opcode_e opcode;
	simd_alu_pkg::func_e func;
	simd_alu_pkg::lane_width_e ww;
	logic [63:0] result;
	logic result_valid;

	// Expected values and test names of operations in flight
	logic [63:0] exp_q [$];
	string name_q [$];
	logic [63:0] exp_word;
	string exp_name;
	logic exp_valid;
	logic [63:0] last_result;

	string test_name;
	int errors;
	int test_errs;
	int checks;
	int tests;
	logic [31:0] rng_state;

	`include "simd_alu_model.svh"

	simd_alu_top DUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.ex_valid     (ex_valid),
		.ra           (ra),
		.rb           (rb),
		.opcode       (opcode),
		.func         (func),
		.ww           (ww),
		.result       (result),
		.result_valid (result_valid)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [63:0] rand_word();
		logic [31:0] hi;
		rng_state = xorshift32(rng_state);
		hi = rng_state;
		rng_state = xorshift32(rng_state);
		return {hi, rng_state};
	endfunction

	// A one in every lane, pushes all-ones lanes into overflow
	function automatic logic [63:0] ones_per_lane(input simd_alu_pkg::lane_width_e w);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < 64 / lane_bits(w); i++) begin
			v = put_elem(v, lane_bits(w), i, 64'd1);
		end
		return v;
	endfunction

	task automatic note_error();
		errors++;
		test_errs++;
	endtask

	// Present one operation on the falling edge
	task automatic drive_op(input simd_alu_pkg::opcode_e op, input simd_alu_pkg::func_e fn,
			input simd_alu_pkg::lane_width_e w, input logic [63:0] a, input logic [63:0] b);
		@(negedge clk);
		ex_valid = 1'b1;
		opcode = op;
		func = fn;
		ww = w;
		ra = a;
		rb = b;
		exp_q.push_back(expected_result(op, fn, w, a, b));
		name_q.push_back(test_name);
	endtask

	task automatic drive_random(input simd_alu_pkg::func_e fn,
			input simd_alu_pkg::lane_width_e w);
		logic [63:0] a;
		logic [63:0] b;
		a = rand_word();
		b = rand_word();
		drive_op(simd_alu_pkg::R_ALU, fn, w, a, b);
	endtask

	// Go idle, let the queue drain, report the test
	task automatic end_test();
		int wait_cycles;
		wait_cycles = 0;
		@(negedge clk);
		ex_valid = 1'b0;
		// Idle inputs select the inverse of the last expected result
		opcode = simd_alu_pkg::R_ALU;
		func = simd_alu_pkg::VMOV;
		if (exp_q.size() != 0) begin
			ra = ~exp_q[$];
		end
		while (exp_q.size() != 0 && wait_cycles < 8) begin
			@(negedge clk);
			wait_cycles++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout: %0d results of test %s never arrived", exp_q.size(), test_name);
			note_error();
			exp_q.delete();
			name_q.delete();
		end
		$display("test %-10s done, %0d errors", test_name, test_errs);
		tests++;
		test_errs = 0;
	endtask

	// Inputs sampled at the edge, result checked one cycle after ex_valid
	always @(posedge clk) begin
		if (!rst_n) begin
			exp_valid = 1'b0;
			last_result = '0;
		end else begin
			checks++;
			assert (result_valid == exp_valid) else begin
				$display("mismatch %s: result_valid expected %0b, actual %0b",
					test_name, exp_valid, result_valid);
				note_error();
			end
			if (result_valid && exp_q.size() != 0) begin
				exp_word = exp_q.pop_front();
				exp_name = name_q.pop_front();
				assert (result == exp_word) else begin
					$display("mismatch %s: expected %h, actual %h", exp_name, exp_word, result);
					note_error();
				end
				last_result = result;
			end else if (!result_valid) begin
				// Holds while idle
				assert (result == last_result) else begin
					$display("mismatch %s: held result expected %h, actual %h",
						test_name, last_result, result);
					note_error();
				end
			end
			exp_valid = ex_valid;
		end
	end

	initial begin
		simd_alu_pkg::lane_width_e wsel;
		rst_n = 1'b0;
		ex_valid = 1'b0;
		ra = '0;
		rb = '0;
		opcode = simd_alu_pkg::NOP;
		func = simd_alu_pkg::VNOP;
		ww = simd_alu_pkg::WIDTH_8;
		rng_state = 32'hc9ca324c;
		errors = 0;
		test_errs = 0;
		checks = 0;
		tests = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		test_name = "burst";
		assert (result == '0 && result_valid == 1'b0) else begin
			$display("mismatch %s: after reset expected 0 and 0, actual %h and %0b",
				test_name, result, result_valid);
			note_error();
		end
		for (int i = 0; i < 6; i++) begin
			drive_random(simd_alu_pkg::VADD, simd_alu_pkg::WIDTH_16);
			drive_random(simd_alu_pkg::VXOR, simd_alu_pkg::WIDTH_8);
		end
		end_test();

		test_name = "bitwise";
		for (int i = 0; i < 4; i++) begin
			drive_random(simd_alu_pkg::VAND, simd_alu_pkg::WIDTH_8);
			drive_random(simd_alu_pkg::VOR, simd_alu_pkg::WIDTH_32);
			drive_random(simd_alu_pkg::VXOR, simd_alu_pkg::WIDTH_64);
			drive_random(simd_alu_pkg::VNOT, simd_alu_pkg::WIDTH_16);
			drive_random(simd_alu_pkg::VMOV, simd_alu_pkg::WIDTH_8);
		end
		drive_random(simd_alu_pkg::VNOP, simd_alu_pkg::WIDTH_8);
		drive_random(simd_alu_pkg::func_e'(6'b111110), simd_alu_pkg::WIDTH_8);
		drive_op(simd_alu_pkg::LOAD, simd_alu_pkg::VADD, simd_alu_pkg::WIDTH_8, '1, '1);
		drive_op(simd_alu_pkg::STORE, simd_alu_pkg::VOR, simd_alu_pkg::WIDTH_8, '1, '1);
		drive_op(simd_alu_pkg::BRANCH_EZ, simd_alu_pkg::VMOV, simd_alu_pkg::WIDTH_8, '1, '1);
		drive_op(simd_alu_pkg::BRANCH_NZ, simd_alu_pkg::VNOT, simd_alu_pkg::WIDTH_8, '0, '1);
		drive_op(simd_alu_pkg::NOP, simd_alu_pkg::VXOR, simd_alu_pkg::WIDTH_8, '1, '0);
		end_test();

		test_name = "add_sub";
		for (int w = 0; w < 4; w++) begin
			wsel = simd_alu_pkg::lane_width_e'(w);
			// All-ones plus one, zero minus one
			drive_op(simd_alu_pkg::R_ALU, simd_alu_pkg::VADD, wsel, '1, ones_per_lane(wsel));
			drive_op(simd_alu_pkg::R_ALU, simd_alu_pkg::VSUB, wsel, '0, ones_per_lane(wsel));
			drive_random(simd_alu_pkg::VADD, wsel);
			drive_random(simd_alu_pkg::VSUB, wsel);
		end
		end_test();

		test_name = "mul_sq";
		for (int w = 0; w < 4; w++) begin
			wsel = simd_alu_pkg::lane_width_e'(w);
			drive_random(simd_alu_pkg::VMULEU, wsel);
			drive_random(simd_alu_pkg::VMULOU, wsel);
			drive_random(simd_alu_pkg::VSQEU, wsel);
			drive_random(simd_alu_pkg::VSQOU, wsel);
			drive_op(simd_alu_pkg::R_ALU, simd_alu_pkg::VMULEU, wsel, '1, '1);
		end
		end_test();

		test_name = "shift_rot";
		for (int w = 0; w < 4; w++) begin
			wsel = simd_alu_pkg::lane_width_e'(w);
			for (int i = 0; i < 2; i++) begin
				drive_random(simd_alu_pkg::VSLL, wsel);
				drive_random(simd_alu_pkg::VSRL, wsel);
				drive_random(simd_alu_pkg::VRTTH, wsel);
			end
		end
		end_test();

		test_name = "sqrt";
		for (int w = 0; w < 4; w++) begin
			wsel = simd_alu_pkg::lane_width_e'(w);
			drive_op(simd_alu_pkg::R_ALU, simd_alu_pkg::VSQRT, wsel, '1, '0);
			drive_op(simd_alu_pkg::R_ALU, simd_alu_pkg::VSQRT, wsel, '0, '0);
			drive_op(simd_alu_pkg::R_ALU, simd_alu_pkg::VSQRT, wsel,
				64'hffff_ffff_0000_0000, '0);
			drive_random(simd_alu_pkg::VSQRT, wsel);
			drive_random(simd_alu_pkg::VSQRT, wsel);
		end
		end_test();

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- verilog/alu_result_stage.sv
`timescale 1ns/10ps
`include "simd_alu_settings.svh"

module alu_result_stage (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  ex_valid,
	input  simd_alu_pkg::word_t   ra,
	input  simd_alu_pkg::word_t   rb,
	input  simd_alu_pkg::opcode_e opcode,
	input  simd_alu_pkg::func_e   func,
	input  simd_alu_pkg::word_t   sum,
	input  simd_alu_pkg::word_t   product,
	input  simd_alu_pkg::word_t   root,
	input  simd_alu_pkg::word_t   shifted,
	output simd_alu_pkg::word_t   result,
	output logic                  result_valid
);

	// Selected value before the execute register
	simd_alu_pkg::word_t next_result;

	always_comb begin
		next_result = '0;
		// Load, store, branch and nop leave the result at zero
		if (opcode == simd_alu_pkg::R_ALU) begin
			case (func)
				// Bitwise group, computed here
				simd_alu_pkg::VAND: next_result = ra & rb;
				simd_alu_pkg::VOR:  next_result = ra | rb;
				simd_alu_pkg::VXOR: next_result = ra ^ rb;
				simd_alu_pkg::VNOT: next_result = ~ra;
				simd_alu_pkg::VMOV: next_result = ra;

				// Lane adder
				simd_alu_pkg::VADD,
				simd_alu_pkg::VSUB: next_result = sum;

				// Multiplier covers both products and squares
				simd_alu_pkg::VMULEU,
				simd_alu_pkg::VMULOU,
				simd_alu_pkg::VSQEU,
				simd_alu_pkg::VSQOU: next_result = product;

				// Shifter
				simd_alu_pkg::VSLL,
				simd_alu_pkg::VSRL,
				simd_alu_pkg::VRTTH: next_result = shifted;

				simd_alu_pkg::VSQRT: next_result = root;

				// VNOP and unused codes
				default: next_result = '0;
			endcase
		end
	end

	// Execute output register
	// result holds when no operation arrives
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
			result <= '0;
		end else begin
			result_valid <= ex_valid;
			if (ex_valid) begin
				result <= next_result;
			end
		end
	end

endmodule

//--- verilog/lane_shift_rotate.sv
`timescale 1ns/10ps
`include "simd_alu_settings.svh"

module lane_shift_rotate (
	input  simd_alu_pkg::word_t       ra,
	input  simd_alu_pkg::word_t       rb,
	input  simd_alu_pkg::lane_width_e ww,
	input  logic                      shift_right,
	input  logic                      rotate,
	output simd_alu_pkg::word_t       shifted
);

	localparam int WB = `SIMD_WORD_BITS;

	// Results for 8, 16, 32 and 64-bit lanes
	wire [WB-1:0] shift_w [4];

	for (genvar w = 0; w < 4; w++) begin : g_width
		localparam int EW = 8 << w;
		localparam int NL = WB / EW;
		// Shift amount bits, log2 of the lane width
		localparam int SB = $clog2(EW);

		for (genvar l = 0; l < NL; l++) begin : g_lane
			localparam int HI = WB - 1 - l * EW;

			logic [EW-1:0] a_lane;
			logic [EW-1:0] b_lane;
			logic [SB-1:0] amt;
			logic [EW-1:0] shl;
			logic [EW-1:0] shr;
			logic [EW-1:0] rot;

			assign a_lane = ra[HI -: EW];
			assign b_lane = rb[HI -: EW];

			// Amount from the low bits of the matching rB lane
			assign amt = b_lane[SB-1:0];

			// Logical, zero fill from either end
			assign shl = a_lane << amt;
			assign shr = a_lane >> amt;

			// Rotate by half a lane is a swap of the halves
			assign rot = {a_lane[EW/2-1:0], a_lane[EW-1:EW/2]};

			assign shift_w[w][HI -: EW] = rotate ? rot : (shift_right ? shr : shl);
		end
	end

	always_comb begin
		case (ww)
			simd_alu_pkg::WIDTH_8:  shifted = shift_w[0];
			simd_alu_pkg::WIDTH_16: shifted = shift_w[1];
			simd_alu_pkg::WIDTH_32: shifted = shift_w[2];
			default:                shifted = shift_w[3];
		endcase
	end

endmodule

//--- verilog/simd_alu_top.sv
`timescale 1ns/10ps
`include "simd_alu_settings.svh"

module simd_alu_top (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      ex_valid,
	input  simd_alu_pkg::word_t       ra,
	input  simd_alu_pkg::word_t       rb,
	input  simd_alu_pkg::opcode_e     opcode,
	input  simd_alu_pkg::func_e       func,
	input  simd_alu_pkg::lane_width_e ww,
	output simd_alu_pkg::word_t       result,
	output logic                      result_valid
);

	// Unit mode levels, decoded once
	logic subtract;
	logic odd_sel;
	logic square_sel;
	logic shift_right;
	logic rotate;

	simd_alu_pkg::word_t sum;
	simd_alu_pkg::word_t product;
	simd_alu_pkg::word_t root;
	simd_alu_pkg::word_t shifted;

	assign subtract    = (func == simd_alu_pkg::VSUB);
	// Odd elements for VMULOU and VSQOU
	assign odd_sel     = (func == simd_alu_pkg::VMULOU) || (func == simd_alu_pkg::VSQOU);
	assign square_sel  = (func == simd_alu_pkg::VSQEU) || (func == simd_alu_pkg::VSQOU);
	assign shift_right = (func == simd_alu_pkg::VSRL);
	assign rotate      = (func == simd_alu_pkg::VRTTH);

	// All units combinational
	lane_adder u_adder (
		.ra       (ra),
		.rb       (rb),
		.ww       (ww),
		.subtract (subtract),
		.sum      (sum)
	);

	lane_multiplier u_mult (
		.ra         (ra),
		.rb         (rb),
		.ww         (ww),
		.odd_sel    (odd_sel),
		.square_sel (square_sel),
		.product    (product)
	);

	lane_sqrt u_sqrt (
		.ra   (ra),
		.ww   (ww),
		.root (root)
	);

	lane_shift_rotate u_shift (
		.ra          (ra),
		.rb          (rb),
		.ww          (ww),
		.shift_right (shift_right),
		.rotate      (rotate),
		.shifted     (shifted)
	);

	// Select and register, one cycle to result
	alu_result_stage u_result (
		.clk          (clk),
		.rst_n        (rst_n),
		.ex_valid     (ex_valid),
		.ra           (ra),
		.rb           (rb),
		.opcode       (opcode),
		.func         (func),
		.sum          (sum),
		.product      (product),
		.root         (root),
		.shifted      (shifted),
		.result       (result),
		.result_valid (result_valid)
	);

endmodule
